// File: rtl/aimbot_pkg.sv
package aimbot_pkg;

    // ********************
    // Field widths
    // ********************

    // RGB565 pixel
    localparam int PIX_W = 16;

    // 11 bits covers 1280 columns
    localparam int COL_W = 11;

    // Row number, also the index field of the payload header
    localparam int ROW_W = 11;

    // Camera id sits above the row number in the index field
    localparam int ID_W = 5;

    // ********************
    // Types
    // ********************

    typedef logic [PIX_W-1:0] pixel_t;

    // Line buffer FSM
    typedef enum logic [1:0] {
        LB_IDLE,
        LB_ARMED,
        LB_CAPTURE,
        LB_READOUT
    } lb_state_t;

    // Payload framer FSM
    typedef enum logic [1:0] {
        FR_IDLE,
        FR_HEADER,
        FR_DATA,
        FR_SUM
    } fr_state_t;

endpackage : aimbot_pkg

// File: rtl/cam_pixel_packer.sv
module cam_pixel_packer
    import aimbot_pkg::*;
#(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic             clk          ,
    input  logic             i_rst_n      ,
    input  logic             i_cam_vsync  ,
    input  logic             i_cam_href   ,
    input  logic             i_cam_byte_en,
    input  logic [7:0]       i_cam_data   ,
    output logic             o_pix_valid  ,
    output pixel_t           o_pix_data   ,
    output logic [COL_W-1:0] o_pix_col    ,
    output logic [ROW_W-1:0] o_pix_row
);

    logic             vsync_q;
    logic             href_q;
    logic             byte_phase;
    logic [7:0]       hi_byte;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;

    logic vsync_rise;
    logic href_fall;
    logic byte_take;
    logic row_active;

    assign vsync_rise = i_cam_vsync & ~vsync_q;
    assign href_fall  = href_q & ~i_cam_href;
    assign byte_take  = i_cam_href & i_cam_byte_en;

    // Rows below V_ACT and columns inside the active width are emitted
    assign row_active = (row_cnt < ROW_W'(V_ACT)) && (col_cnt < COL_W'(H_ACT));

    // ********************
    // Sync edges and counters
    // ********************

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vsync_q     <= 1'b0;
            href_q      <= 1'b0;
            byte_phase  <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
            o_pix_valid <= 1'b0;
        end else begin
            vsync_q     <= i_cam_vsync;
            href_q      <= i_cam_href;
            o_pix_valid <= 1'b0;
            if (vsync_rise) begin
                byte_phase <= 1'b0;
                col_cnt    <= '0;
                row_cnt    <= '0;
            end else if (href_fall) begin
                byte_phase <= 1'b0;
                col_cnt    <= '0;
                // Hold at V_ACT so late rows stay suppressed until vsync
                if (row_cnt < ROW_W'(V_ACT))
                    row_cnt <= row_cnt + 1'b1;
            end else if (byte_take) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    o_pix_valid <= row_active;
                    col_cnt     <= col_cnt + 1'b1;
                end
            end
        end
    end

    // High byte comes first in each pair
    always_ff @(posedge clk) begin
        if (byte_take && !byte_phase)
            hi_byte <= i_cam_data;
        if (byte_take && byte_phase) begin
            o_pix_data <= {hi_byte, i_cam_data};
            o_pix_col  <= col_cnt;
            o_pix_row  <= row_cnt;
        end
    end

endmodule : cam_pixel_packer

// File: rtl/line_buffer.sv
module line_buffer
    import aimbot_pkg::*;
#(
    parameter int H_ACT = 1280
) (
    input  logic             clk        ,
    input  logic             i_rst_n    ,
    input  logic             i_trig     ,
    input  logic             i_pix_valid,
    input  pixel_t           i_pix_data ,
    input  logic [COL_W-1:0] i_pix_col  ,
    input  logic [ROW_W-1:0] i_pix_row  ,
    input  logic             i_read_en  ,
    output logic             o_acquire  ,
    output logic [ROW_W-1:0] o_row      ,
    output pixel_t           o_rd_data  ,
    output logic             o_line_err
);

    localparam int AW = (H_ACT > 1) ? $clog2(H_ACT) : 1;

    lb_state_t     state;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic          row_start;
    logic          wr_en;

    pixel_t mem [H_ACT];

    // Capture always begins at column 0 so a stored row is never partial
    assign row_start = i_pix_valid && (i_pix_col == '0);

    assign wr_en = ((state == LB_ARMED) && row_start) ||
                   ((state == LB_CAPTURE) && i_pix_valid);

    // ********************
    // Control FSM
    // ********************

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= LB_IDLE;
            wr_addr    <= '0;
            rd_addr    <= '0;
            o_acquire  <= 1'b0;
            o_row      <= '0;
            o_line_err <= 1'b0;
        end else begin
            o_acquire <= 1'b0;

            // A trigger is only taken while idle
            if (i_trig && (state != LB_IDLE))
                o_line_err <= 1'b1;

            case (state)
                LB_IDLE: begin
                    wr_addr <= '0;
                    if (i_trig)
                        state <= LB_ARMED;
                end
                LB_ARMED: begin
                    if (row_start) begin
                        o_row   <= i_pix_row;
                        wr_addr <= wr_addr + 1'b1;
                        state   <= LB_CAPTURE;
                    end
                end
                LB_CAPTURE: begin
                    if (i_pix_valid) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == AW'(H_ACT - 1)) begin
                            o_acquire <= 1'b1;
                            rd_addr   <= '0;
                            state     <= LB_READOUT;
                        end
                    end
                end
                LB_READOUT: begin
                    if (i_read_en) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (rd_addr == AW'(H_ACT - 1))
                            state <= LB_IDLE;
                    end
                end
                default: state <= LB_IDLE;
            endcase
        end
    end

    // ********************
    // Pixel memory
    // ********************

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= i_pix_data;
    end

    // Data follows read_en by one cycle
    always_ff @(posedge clk) begin
        if (i_read_en)
            o_rd_data <= mem[rd_addr];
    end

endmodule : line_buffer

// File: rtl/udp_line_framer.sv
module udp_line_framer
    import aimbot_pkg::*;
#(
    parameter int              H_ACT  = 1280,
    parameter logic [ID_W-1:0] CAM_ID = 5'b10000
) (
    input  logic             clk       ,
    input  logic             i_rst_n   ,
    input  logic             i_acquire ,
    input  logic [ROW_W-1:0] i_row     ,
    input  pixel_t           i_rd_data ,
    output logic             o_read_en ,
    output logic             o_tx_valid,
    output logic [7:0]       o_tx_data ,
    output logic             o_tx_sof  ,
    output logic             o_tx_eof
);

    localparam int          CW  = $clog2(2 * H_ACT);
    localparam logic [15:0] LEN = 16'(2 * H_ACT);

    fr_state_t     state;
    logic [CW-1:0] cnt;
    logic [15:0]   index;
    logic [7:0]    sum;
    logic [7:0]    tx_byte;
    logic          rd_next;

    // ********************
    // Next payload byte
    // ********************

    always_comb begin
        tx_byte = sum;
        case (state)
            FR_HEADER: begin
                case (cnt[1:0])
                    2'd0:    tx_byte = index[15:8];
                    2'd1:    tx_byte = index[7:0];
                    2'd2:    tx_byte = LEN[15:8];
                    default: tx_byte = LEN[7:0];
                endcase
            end
            FR_DATA:
                tx_byte = cnt[0] ? i_rd_data[7:0] : i_rd_data[PIX_W-1:8];
            default:
                tx_byte = sum;
        endcase
    end

    // Fetch the first pixel while the length goes out, then each next
    // pixel while the current high byte goes out
    assign rd_next = ((state == FR_HEADER) && (cnt == CW'(2))) ||
                     ((state == FR_DATA) && !cnt[0] &&
                      (cnt != CW'(2 * H_ACT - 2)));

    // ********************
    // Framer FSM
    // ********************

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= FR_IDLE;
            cnt        <= '0;
            sum        <= '0;
            o_read_en  <= 1'b0;
            o_tx_valid <= 1'b0;
            o_tx_sof   <= 1'b0;
            o_tx_eof   <= 1'b0;
        end else begin
            o_read_en  <= rd_next;
            o_tx_valid <= (state != FR_IDLE);
            o_tx_sof   <= (state == FR_HEADER) && (cnt == '0);
            o_tx_eof   <= (state == FR_SUM);
            if (state != FR_IDLE)
                sum <= sum + tx_byte;

            case (state)
                FR_IDLE: begin
                    if (i_acquire) begin
                        cnt   <= '0;
                        sum   <= '0;
                        state <= FR_HEADER;
                    end
                end
                FR_HEADER: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(3)) begin
                        cnt   <= '0;
                        state <= FR_DATA;
                    end
                end
                FR_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(2 * H_ACT - 1))
                        state <= FR_SUM;
                end
                FR_SUM:  state <= FR_IDLE;
                default: state <= FR_IDLE;
            endcase
        end
    end

    // The index is latched on acquire and the payload byte is registered every cycle
    always_ff @(posedge clk) begin
        if ((state == FR_IDLE) && i_acquire)
            index <= {CAM_ID, i_row};
        o_tx_data <= tx_byte;
    end

endmodule : udp_line_framer

// File: rtl/aim_line_top.sv
module aim_line_top
    import aimbot_pkg::*;
#(
    parameter int              H_ACT  = 1280,
    parameter int              V_ACT  = 720,
    parameter logic [ID_W-1:0] CAM_ID = 5'b10000
) (
    input  logic       clk          ,
    input  logic       i_rst_n      ,
    input  logic       i_cam_vsync  ,
    input  logic       i_cam_href   ,
    input  logic       i_cam_byte_en,
    input  logic [7:0] i_cam_data   ,
    input  logic       i_trig       ,
    output logic       o_tx_valid   ,
    output logic [7:0] o_tx_data    ,
    output logic       o_tx_sof     ,
    output logic       o_tx_eof     ,
    output logic       o_line_err
);

    // Packer to line buffer
    logic             pix_valid;
    pixel_t           pix_data;
    logic [COL_W-1:0] pix_col;
    logic [ROW_W-1:0] pix_row;

    // Line buffer and framer
    logic             acquire;
    logic [ROW_W-1:0] row;
    logic             read_en;
    pixel_t           rd_data;

    cam_pixel_packer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_packer (
        .clk          (clk          ),
        .i_rst_n      (i_rst_n      ),
        .i_cam_vsync  (i_cam_vsync  ),
        .i_cam_href   (i_cam_href   ),
        .i_cam_byte_en(i_cam_byte_en),
        .i_cam_data   (i_cam_data   ),
        .o_pix_valid  (pix_valid    ),
        .o_pix_data   (pix_data     ),
        .o_pix_col    (pix_col      ),
        .o_pix_row    (pix_row      )
    );

    line_buffer #(.H_ACT(H_ACT)) u_line_buffer (
        .clk        (clk       ),
        .i_rst_n    (i_rst_n   ),
        .i_trig     (i_trig    ),
        .i_pix_valid(pix_valid ),
        .i_pix_data (pix_data  ),
        .i_pix_col  (pix_col   ),
        .i_pix_row  (pix_row   ),
        .i_read_en  (read_en   ),
        .o_acquire  (acquire   ),
        .o_row      (row       ),
        .o_rd_data  (rd_data   ),
        .o_line_err (o_line_err)
    );

    udp_line_framer #(.H_ACT(H_ACT), .CAM_ID(CAM_ID)) u_framer (
        .clk       (clk       ),
        .i_rst_n   (i_rst_n   ),
        .i_acquire (acquire   ),
        .i_row     (row       ),
        .i_rd_data (rd_data   ),
        .o_read_en (read_en   ),
        .o_tx_valid(o_tx_valid),
        .o_tx_data (o_tx_data ),
        .o_tx_sof  (o_tx_sof  ),
        .o_tx_eof  (o_tx_eof  )
    );

endmodule : aim_line_top

// File: dv/tb_clk_gen.sv
module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    // Reset spans the first 10 rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        #10;
        o_rst_n = 1'b1;
    end

endmodule : tb_clk_gen

// File: dv/aim_line_asserts.sv
module aim_line_asserts
    import aimbot_pkg::*;
(
    input logic      clk       ,
    input logic      i_rst_n   ,
    input logic      i_acquire ,
    input logic      i_line_err,
    input logic      i_read_en ,
    input lb_state_t i_state
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // ********************
    // Line buffer protocol
    // ********************

    acquire_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_acquire |=> !i_acquire)
    else begin
        $error("o_acquire lasted more than one cycle");
        fail_cnt++;
    end

    // The capture FSM leaves LB_CAPTURE on the same edge that raises acquire
    acquire_source: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(i_acquire) |-> ($past(i_state) == LB_CAPTURE))
    else begin
        $error("o_acquire rose outside of LB_CAPTURE");
        fail_cnt++;
    end

    line_err_sticky: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$fell(i_line_err))
    else begin
        $error("o_line_err fell while out of reset");
        fail_cnt++;
    end

    read_in_readout: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_read_en |-> (i_state == LB_READOUT))
    else begin
        $error("i_read_en seen outside of LB_READOUT");
        fail_cnt++;
    end

endmodule : aim_line_asserts

bind line_buffer aim_line_asserts u_asserts (
    .clk       (clk       ),
    .i_rst_n   (i_rst_n   ),
    .i_acquire (o_acquire ),
    .i_line_err(o_line_err),
    .i_read_en (i_read_en ),
    .i_state   (state     )
);

// File: dv/aim_line_tb.sv
module aim_line_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         H_ACT   = 16;
    localparam int         V_ACT   = 6;
    localparam logic [4:0] CAM_ID  = 5'b10000;
    localparam int         TIMEOUT = 400;

    logic       clk;
    logic       rst_n;
    logic       cam_vsync;
    logic       cam_href;
    logic       cam_byte_en;
    logic [7:0] cam_data;
    logic       trig;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_sof;
    logic       tx_eof;
    logic       line_err;

    logic [31:0] rng = 32'he744_4a92;
    logic [7:0]  model [V_ACT][2*H_ACT];
    logic [7:0]  cur_q[$];
    logic [7:0]  rx_frame[$];
    logic        in_frame = 1'b0;
    int          sof_seen = 0;
    int          gap_seen = 0;
    int          rx_sof = 0;
    int          rx_gaps = 0;
    int          frame_cnt = 0;
    int          stray_cnt = 0;
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        timed_out = 1'b0;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    aim_line_top #(.H_ACT(H_ACT), .V_ACT(V_ACT), .CAM_ID(CAM_ID)) i_dut (
        .clk          (clk        ),
        .i_rst_n      (rst_n      ),
        .i_cam_vsync  (cam_vsync  ),
        .i_cam_href   (cam_href   ),
        .i_cam_byte_en(cam_byte_en),
        .i_cam_data   (cam_data   ),
        .i_trig       (trig       ),
        .o_tx_valid   (tx_valid   ),
        .o_tx_data    (tx_data    ),
        .o_tx_sof     (tx_sof     ),
        .o_tx_eof     (tx_eof     ),
        .o_line_err   (line_err   )
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ********************
    // Camera stimulus
    // ********************

    task automatic drive_row(input int r, input bit busy);
        logic [31:0] rv;
        cam_href = 1'b1;
        for (int b = 0; b < 2 * H_ACT; b++) begin
            rv = next_rand();
            // Occasional stall with the byte enable held low
            if (rv[9:8] == 2'b00) begin
                cam_byte_en = 1'b0;
                repeat (1 + rv[10]) tick();
            end
            cam_byte_en = 1'b1;
            cam_data    = rv[7:0];
            model[r][b] = rv[7:0];
            trig        = busy && (b == H_ACT);
            tick();
            trig = 1'b0;
        end
        cam_byte_en = 1'b0;
        cam_href    = 1'b0;
    endtask

    // Row blanking is 4 to 11 cycles, a trigger goes in its second cycle
    task automatic drive_frame(input int trig_row, input int busy_row);
        logic [31:0] rv;
        cam_vsync = 1'b1;
        repeat (2) tick();
        cam_vsync = 1'b0;
        for (int r = 0; r < V_ACT; r++) begin
            rv = next_rand();
            tick();
            trig = (r == trig_row);
            tick();
            trig = 1'b0;
            repeat (2 + rv[2:0]) tick();
            drive_row(r, r == busy_row);
        end
        rv = next_rand();
        repeat (4 + rv[3:0]) tick();
    endtask

    task automatic wait_frame(input int count);
        int n;
        n = 0;
        while ((frame_cnt < count) && (n < TIMEOUT)) begin
            tick();
            n++;
        end
        if (frame_cnt < count) begin
            $display("timeout: frame %0d did not arrive in %0d cycles", count, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // ********************
    // Payload collector
    // ********************

    always @(negedge clk) begin
        if (in_frame || (tx_valid && tx_sof)) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                cur_q.delete();
                sof_seen = 0;
                gap_seen = 0;
            end
            if (!tx_valid) begin
                gap_seen++;
            end else begin
                cur_q.push_back(tx_data);
                if (tx_sof)
                    sof_seen++;
                if (tx_eof) begin
                    rx_frame = cur_q;
                    rx_sof   = sof_seen;
                    rx_gaps  = gap_seen;
                    in_frame = 1'b0;
                    frame_cnt++;
                end
            end
        end else if (tx_valid) begin
            stray_cnt++;
        end
    end

    // Index, length, pixel bytes in arrival order, then the byte sum
    task automatic check_frame(input int row);
        logic [7:0]  exp_q[$];
        logic [15:0] index;
        logic [15:0] len;
        logic [7:0]  sum;
        index = {CAM_ID, 11'(row)};
        len   = 16'(2 * H_ACT);
        exp_q = {index[15:8], index[7:0], len[15:8], len[7:0]};
        for (int i = 0; i < 2 * H_ACT; i++)
            exp_q.push_back(model[row][i]);
        sum = '0;
        foreach (exp_q[i])
            sum += exp_q[i];
        exp_q.push_back(sum);
        check_value("frame length", rx_frame.size(), exp_q.size());
        check_value("o_tx_sof count", rx_sof, 1);
        check_value("o_tx_valid gaps", rx_gaps, 0);
        check_value("bytes outside frame", stray_cnt, 0);
        foreach (rx_frame[i])
            if (i < exp_q.size())
                check_value($sformatf("o_tx_data[%0d]", i), rx_frame[i], exp_q[i]);
    endtask

    task automatic test_capture(input int row, input bit busy);
        int errs_before;
        int frames_before;
        errs_before   = err_cnt;
        frames_before = frame_cnt;
        drive_frame(row, busy ? row : -1);
        wait_frame(frames_before + 1);
        if (timed_out)
            return;
        check_frame(row);
        check_value("o_line_err", line_err, busy);
        repeat (2 * H_ACT + 20) tick();
        check_value("frame count", frame_cnt - frames_before, 1);
        check_value("o_line_err", line_err, busy);
        report_test($sformatf("%s row %0d", busy ? "busy trigger" : "capture", row),
                    errs_before);
    endtask

    initial begin
        int errs_total;
        int n;
        cam_vsync   = 1'b0;
        cam_href    = 1'b0;
        cam_byte_en = 1'b0;
        cam_data    = 8'h00;
        trig        = 1'b0;
        n = 0;
        while (!rst_n && (n < 50)) begin
            tick();
            n++;
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            n = err_cnt;
            check_value("o_tx_valid", tx_valid, 0);
            check_value("o_tx_sof", tx_sof, 0);
            check_value("o_tx_eof", tx_eof, 0);
            check_value("o_line_err", line_err, 0);
            drive_frame(-1, -1);
            repeat (2 * H_ACT + 20) tick();
            check_value("frame count", frame_cnt, 0);
            check_value("bytes outside frame", stray_cnt, 0);
            report_test("idle after reset", n);
        end
        for (int k = 0; k < 4; k++)
            if (!timed_out)
                test_capture((k == 0) ? 0 : 1 + int'(next_rand() % (V_ACT - 1)), 1'b0);
        if (!timed_out)
            test_capture(1 + int'(next_rand() % (V_ACT - 1)), 1'b1);

        errs_total = err_cnt + i_dut.u_line_buffer.u_asserts.fail_cnt;
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, i_dut.u_line_buffer.u_asserts.fail_cnt);
        if ((errs_total == 0) && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : aim_line_tb

// File: compile.f
rtl/aimbot_pkg.sv
rtl/cam_pixel_packer.sv
rtl/line_buffer.sv
rtl/udp_line_framer.sv
rtl/aim_line_top.sv
dv/tb_clk_gen.sv
dv/aim_line_asserts.sv
dv/aim_line_tb.sv
